// ==== source/ecc_pkg.sv ====
`default_nettype none

// shared definitions for the 32-bit SECDED path
package ecc_pkg;

   localparam int DATA_W        = 32;              // protected data bits
   localparam int HAM_W         = 6;               // hamming check bits
   localparam int CHECK_W       = HAM_W + 1;       // hamming bits plus overall parity
   localparam int NUM_POSITIONS = DATA_W + CHECK_W; // stored bits in one codeword

   typedef logic [DATA_W-1:0]        data_t;
   typedef logic [CHECK_W-1:0]       check_t;      // [5:0] hamming, [6] overall parity
   typedef logic [CHECK_W-1:0]       syndrome_t;   // [5:0] position, [6] parity mismatch
   typedef logic [NUM_POSITIONS-1:0] codeword_t;   // position k lives at bit k-1

   // data bits feeding each hamming check bit
   // a data bit belongs to set i when its codeword position has bit i set
   localparam data_t CHECK_COVER [HAM_W] = '{
      32'h56AA_AD5B,   // check 0, position 1
      32'h9B33_366D,   // check 1, position 2
      32'hE3C3_C78E,   // check 2, position 4
      32'h03FC_07F0,   // check 3, position 8
      32'h03FF_F800,   // check 4, position 16
      32'hFC00_0000    // check 5, position 32
   };

   // six hamming bits of a data word, parity of each cover set
   function automatic logic [HAM_W-1:0] hamming_bits(input data_t d);
      logic [HAM_W-1:0] h;
      for (int i = 0; i < HAM_W; i++) begin
         h[i] = ^(d & CHECK_COVER[i]);
      end
      return h;
   endfunction

endpackage

`default_nettype wire

// ==== source/ecc_encode_stage.sv ====
`default_nettype none

// write side, one register stage from data word to stored check bits
module ecc_encode_stage (
   input  logic           clk,
   input  logic           rst_l,
   input  logic           wr_valid,
   input  ecc_pkg::data_t wr_data,

   output logic            enc_valid,
   output ecc_pkg::data_t  enc_data,
   output ecc_pkg::check_t enc_ecc
);

   logic [ecc_pkg::HAM_W-1:0] ham;     // hamming bits of the incoming word
   logic                      parity;  // overall parity over data and hamming bits
   ecc_pkg::check_t           ecc_calc;

   always_comb begin
      ham      = ecc_pkg::hamming_bits(wr_data);
      parity   = (^wr_data) ^ (^ham);
      ecc_calc = {parity, ham};
   end

   // valid strobe runs every cycle, payload loads only with a word
   always_ff @(posedge clk) begin
      if (!rst_l) begin
         enc_valid <= 1'b0;
         enc_data  <= '0;
         enc_ecc   <= '0;
      end else begin
         enc_valid <= wr_valid;
         if (wr_valid) begin
            enc_data <= wr_data;
            enc_ecc  <= ecc_calc;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/ecc_syndrome_stage.sv ====
`default_nettype none

// read side stage 1
// recomputes the check bits of the received word and compares them
// with the stored ones, the result travels with the word into stage 2
module ecc_syndrome_stage (
   input  logic            clk,
   input  logic            rst_l,
   input  logic            rd_valid,
   input  ecc_pkg::data_t  rd_data,
   input  ecc_pkg::check_t rd_ecc,
   input  logic            sed_ded,     // detect only, no correction

   output logic              syn_valid,
   output ecc_pkg::data_t    syn_data,
   output ecc_pkg::check_t   syn_ecc,
   output ecc_pkg::syndrome_t syn_check
);

   logic [ecc_pkg::HAM_W-1:0] ham_rx;       // hamming bits recomputed from rd_data
   logic                      par_mismatch; // odd parity over all 39 received bits
   ecc_pkg::syndrome_t        syn_calc;

   always_comb begin
      ham_rx = ecc_pkg::hamming_bits(rd_data);

      // stored parity covers data and hamming bits, so a clean word
      // xors to zero over all 39 bits
      par_mismatch = (^rd_data) ^ (^rd_ecc);

      syn_calc[ecc_pkg::HAM_W-1:0] = ham_rx ^ rd_ecc[ecc_pkg::HAM_W-1:0];

      // in detect only mode the parity term is dropped, every nonzero
      // syndrome then classifies as a double error downstream
      syn_calc[ecc_pkg::CHECK_W-1] = par_mismatch & ~sed_ded;
   end

   always_ff @(posedge clk) begin
      if (!rst_l) begin
         syn_valid <= 1'b0;
         syn_data  <= '0;
         syn_ecc   <= '0;
         syn_check <= '0;
      end else begin
         syn_valid <= rd_valid;
         if (rd_valid) begin
            syn_data  <= rd_data;   // received word as is
            syn_ecc   <= rd_ecc;
            syn_check <= syn_calc;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/ecc_correct_stage.sv ====
`default_nettype none

// read side stage 2
// classifies the syndrome, fixes a single flipped bit anywhere in the
// 39 stored bits and hands back clean data with its check bits
module ecc_correct_stage (
   input  logic               clk,
   input  logic               rst_l,
   input  logic               syn_valid,
   input  ecc_pkg::data_t     syn_data,
   input  ecc_pkg::check_t    syn_ecc,
   input  ecc_pkg::syndrome_t syn_check,

   output logic            fix_valid,
   output ecc_pkg::data_t  fix_data,
   output ecc_pkg::check_t fix_ecc,
   output logic            single_err,
   output logic            double_err
);

   // only the overall parity disagrees, so the parity bit itself flipped
   localparam ecc_pkg::syndrome_t SYN_PARITY_ONLY = 7'b100_0000;

   logic                 syn_nonzero;
   logic                 single_calc;
   logic                 double_calc;
   ecc_pkg::codeword_t   err_mask;    // one hot over codeword positions
   ecc_pkg::codeword_t   cw_rx;       // received bits in hamming order
   ecc_pkg::codeword_t   cw_fix;
   ecc_pkg::data_t       data_fix;
   ecc_pkg::check_t      ecc_fix;

   always_comb begin
      syn_nonzero = (syn_check != '0);
      single_calc = syn_valid & syn_nonzero & syn_check[6];
      double_calc = syn_valid & syn_nonzero & ~syn_check[6];

      // position k of the codeword sits at bit k-1
      for (int i = 1; i <= ecc_pkg::NUM_POSITIONS; i++) begin
         err_mask[i-1] = (syn_check[5:0] == 6'(i));
      end

      // check bits at powers of two, parity on top
      cw_rx = {syn_ecc[6], syn_data[31:26], syn_ecc[5], syn_data[25:11],
               syn_ecc[4], syn_data[10:4], syn_ecc[3], syn_data[3:1],
               syn_ecc[2], syn_data[0], syn_ecc[1:0]};

      cw_fix = single_calc ? (cw_rx ^ err_mask) : cw_rx;

      data_fix = {cw_fix[37:32], cw_fix[30:16], cw_fix[14:8], cw_fix[6:4], cw_fix[2]};

      // the mask never reaches the parity bit, fix it from the syndrome
      ecc_fix = {cw_fix[38] ^ (syn_check == SYN_PARITY_ONLY),
                 cw_fix[31], cw_fix[15], cw_fix[7], cw_fix[3], cw_fix[1:0]};
   end

   always_ff @(posedge clk) begin
      if (!rst_l) begin
         fix_valid  <= 1'b0;
         single_err <= 1'b0;
         double_err <= 1'b0;
         fix_data   <= '0;
         fix_ecc    <= '0;
      end else begin
         fix_valid  <= syn_valid;
         single_err <= single_calc;   // already qualified by syn_valid
         double_err <= double_calc;
         if (syn_valid) begin
            fix_data <= data_fix;
            fix_ecc  <= ecc_fix;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/ecc_pipe_top.sv ====
`default_nettype none

// SECDED protection path
// write side encodes in one cycle, read side checks and corrects in two
module ecc_pipe_top (
   input  logic            clk,
   input  logic            rst_l,

   // write side
   input  logic            wr_valid,
   input  ecc_pkg::data_t  wr_data,
   output logic            enc_valid,
   output ecc_pkg::data_t  enc_data,
   output ecc_pkg::check_t enc_ecc,

   // read side
   input  logic            rd_valid,
   input  ecc_pkg::data_t  rd_data,
   input  ecc_pkg::check_t rd_ecc,
   input  logic            sed_ded,
   output logic            fix_valid,
   output ecc_pkg::data_t  fix_data,
   output ecc_pkg::check_t fix_ecc,
   output logic            single_err,
   output logic            double_err
);

   // stage 1 to stage 2 of the decoder
   logic               syn_valid;
   ecc_pkg::data_t     syn_data;
   ecc_pkg::check_t    syn_ecc;
   ecc_pkg::syndrome_t syn_check;

   ecc_encode_stage u_encode (
      .clk       (clk),
      .rst_l     (rst_l),
      .wr_valid  (wr_valid),
      .wr_data   (wr_data),
      .enc_valid (enc_valid),
      .enc_data  (enc_data),
      .enc_ecc   (enc_ecc)
   );

   ecc_syndrome_stage u_syndrome (
      .clk       (clk),
      .rst_l     (rst_l),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .rd_ecc    (rd_ecc),
      .sed_ded   (sed_ded),
      .syn_valid (syn_valid),
      .syn_data  (syn_data),
      .syn_ecc   (syn_ecc),
      .syn_check (syn_check)
   );

   ecc_correct_stage u_correct (
      .clk        (clk),
      .rst_l      (rst_l),
      .syn_valid  (syn_valid),
      .syn_data   (syn_data),
      .syn_ecc    (syn_ecc),
      .syn_check  (syn_check),
      .fix_valid  (fix_valid),
      .fix_data   (fix_data),
      .fix_ecc    (fix_ecc),
      .single_err (single_err),
      .double_err (double_err)
   );

endmodule

`default_nettype wire

// ==== include/ecc_ref_model.svh ====
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

// behavioral model of the SECDED code, included inside the testbench module
// stored word layout for the flip helpers is {check, data}, bit 32 is check bit 0

// 32-bit xorshift, never returns zero for a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// check bits bit by bit from the cover sets
function automatic ecc_pkg::check_t secded_check_bits(input ecc_pkg::data_t d);
   ecc_pkg::check_t c;
   c = '0;
   for (int i = 0; i < ecc_pkg::HAM_W; i++) begin
      for (int b = 0; b < ecc_pkg::DATA_W; b++) begin
         if (ecc_pkg::CHECK_COVER[i][b])
            c[i] = c[i] ^ d[b];
      end
   end
   c[6] = (^d) ^ (^c[5:0]);   // overall parity
   return c;
endfunction

// flip one stored bit, pos 0 to 38
function automatic logic [38:0] flip_stored_bit(input logic [38:0] word,
                                                input int unsigned pos);
   logic [38:0] w;
   w = word;
   w[pos] = ~w[pos];
   return w;
endfunction

// expected {double_err, single_err} for a word with nflips flipped bits
function automatic logic [1:0] expected_flags(input int unsigned nflips,
                                              input logic sed_ded,
                                              input logic parity_only);
   logic [1:0] f;
   if (nflips == 0)
      f = 2'b00;
   else if (sed_ded)
      f = parity_only ? 2'b00 : 2'b10;   // lone parity flip goes unseen
   else if (nflips == 1)
      f = 2'b01;
   else
      f = 2'b10;
   return f;
endfunction

`endif

// ==== verif/ecc_pipe_tb.sv ====
`default_nettype none

// testbench for the SECDED pipeline
// expected results ride in shift registers that match the fixed latencies,
// concurrent assertions compare them with the DUT outputs
module ecc_pipe_tb;
   timeunit 1ns;
   timeprecision 100ps;

   `include "ecc_ref_model.svh"

   localparam int          NUM_WORDS   = 400;            // words sent on each path
   localparam int          RUN_LIMIT   = NUM_WORDS * 4;  // cycles for the stimulus loop
   localparam int          DRAIN_LIMIT = 20;
   localparam logic [31:0] SEED        = 32'd24775;

   logic            clk = 1'b0;
   logic            rst_l;
   logic            wr_valid;
   ecc_pkg::data_t  wr_data;
   logic            enc_valid;
   ecc_pkg::data_t  enc_data;
   ecc_pkg::check_t enc_ecc;
   logic            rd_valid;
   ecc_pkg::data_t  rd_data;
   ecc_pkg::check_t rd_ecc;
   logic            sed_ded;
   logic            fix_valid;
   ecc_pkg::data_t  fix_data;
   ecc_pkg::check_t fix_ecc;
   logic            single_err;
   logic            double_err;

   logic [31:0] rng;
   logic        chk_en;          // off until reset has cleared the flops
   int          wr_sent  = 0;
   int          rd_sent  = 0;
   int          enc_seen = 0;
   int          fix_seen = 0;
   int          cycles;

   // expectation for the word on the inputs right now
   logic            nxt_enc_valid;
   ecc_pkg::data_t  nxt_enc_data;
   ecc_pkg::check_t nxt_enc_ecc;
   logic            nxt_fix_valid;
   logic            nxt_fix_chk;   // payload compared, off for double errors
   ecc_pkg::data_t  nxt_fix_data;
   ecc_pkg::check_t nxt_fix_ecc;
   logic            nxt_single;
   logic            nxt_double;

   // decoder expectation after one edge
   logic            d1_valid;
   logic            d1_chk;
   ecc_pkg::data_t  d1_data;
   ecc_pkg::check_t d1_ecc;
   logic            d1_single;
   logic            d1_double;

   // aligned with the DUT outputs
   logic            exp_enc_valid;
   ecc_pkg::data_t  exp_enc_data;
   ecc_pkg::check_t exp_enc_ecc;
   logic            exp_fix_valid;
   logic            exp_fix_chk;
   ecc_pkg::data_t  exp_fix_data;
   ecc_pkg::check_t exp_fix_ecc;
   logic            exp_single;
   logic            exp_double;

   ecc_pipe_top UUT (
      .clk        (clk),
      .rst_l      (rst_l),
      .wr_valid   (wr_valid),
      .wr_data    (wr_data),
      .enc_valid  (enc_valid),
      .enc_data   (enc_data),
      .enc_ecc    (enc_ecc),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .rd_ecc     (rd_ecc),
      .sed_ded    (sed_ded),
      .fix_valid  (fix_valid),
      .fix_data   (fix_data),
      .fix_ecc    (fix_ecc),
      .single_err (single_err),
      .double_err (double_err)
   );

   initial begin
      forever #2 clk = ~clk;   // 4 ns period
   end

   // 1 deep for the encoder, 2 deep for the decoder
   always @(posedge clk) begin
      if (!rst_l) begin
         exp_enc_valid <= 1'b0;
         d1_valid      <= 1'b0;
         d1_single     <= 1'b0;
         d1_double     <= 1'b0;
         exp_fix_valid <= 1'b0;
         exp_single    <= 1'b0;
         exp_double    <= 1'b0;
      end else begin
         exp_enc_valid <= nxt_enc_valid;
         exp_enc_data  <= nxt_enc_data;
         exp_enc_ecc   <= nxt_enc_ecc;
         d1_valid      <= nxt_fix_valid;
         d1_chk        <= nxt_fix_chk;
         d1_data       <= nxt_fix_data;
         d1_ecc        <= nxt_fix_ecc;
         d1_single     <= nxt_single;
         d1_double     <= nxt_double;
         exp_fix_valid <= d1_valid;
         exp_fix_chk   <= d1_chk;
         exp_fix_data  <= d1_data;
         exp_fix_ecc   <= d1_ecc;
         exp_single    <= d1_single;
         exp_double    <= d1_double;
      end
   end

   // outputs are stable between edges
   always @(negedge clk) begin
      if (enc_valid)
         enc_seen++;
      if (fix_valid)
         fix_seen++;
   end

   task automatic stop_with_fail();
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("mismatch at %t: %s expected %0h actual %0h", $realtime, name, exp_val, act_val);
      stop_with_fail();
   endtask

   task automatic next_random(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   task automatic drive_write(input logic active);
      logic [31:0] d;
      wr_valid      = active;
      nxt_enc_valid = active;
      if (active) begin
         next_random(d);
         wr_data      = d;
         nxt_enc_data = d;
         nxt_enc_ecc  = secded_check_bits(d);
         wr_sent++;
      end
   endtask

   // picks a clean, single or double flipped word, detect only for a quarter
   task automatic drive_read(input logic active);
      logic [31:0]     r;
      logic [31:0]     d;
      logic [31:0]     p;
      ecc_pkg::check_t c;
      logic [38:0]     word_rx;
      logic            mode;
      logic [1:0]      flags;
      int unsigned     nflips;
      int unsigned     pos_a;
      int unsigned     pos_b;
      rd_valid      = active;
      nxt_fix_valid = active;
      nxt_fix_chk   = 1'b0;
      nxt_single    = 1'b0;
      nxt_double    = 1'b0;
      sed_ded       = 1'b0;
      if (active) begin
         next_random(r);
         next_random(d);
         next_random(p);
         c    = secded_check_bits(d);
         mode = (r[1:0] == 2'b11);
         if (mode)
            nflips = r[2] ? 1 : 0;
         else if (r[3:2] == 2'd0)
            nflips = 0;
         else if (r[3:2] == 2'd3)
            nflips = 2;
         else
            nflips = 1;
         pos_a = p % 32'd39;
         if (r[11:8] == 4'd0)
            pos_a = 38;                              // lone parity bit now and then
         pos_b = (pos_a + 1 + ((p >> 8) % 32'd38)) % 39;   // never equal to pos_a
         word_rx = {c, d};
         if (nflips > 0)
            word_rx = flip_stored_bit(word_rx, pos_a);
         if (nflips > 1)
            word_rx = flip_stored_bit(word_rx, pos_b);
         flags = expected_flags(nflips, mode, pos_a == 32'd38);

         rd_data    = word_rx[31:0];
         rd_ecc     = word_rx[38:32];
         sed_ded    = mode;
         nxt_double = flags[1];
         nxt_single = flags[0];
         nxt_fix_chk = (nflips < 2);
         if (mode) begin
            nxt_fix_data = word_rx[31:0];   // nothing corrected
            nxt_fix_ecc  = word_rx[38:32];
         end else begin
            nxt_fix_data = d;
            nxt_fix_ecc  = c;
         end
         rd_sent++;
      end
   endtask

   a_enc_valid: assert property (@(posedge clk) disable iff (!chk_en)
      enc_valid == exp_enc_valid)
      else report_mismatch("enc_valid", 32'($sampled(exp_enc_valid)), 32'($sampled(enc_valid)));
   a_enc_data: assert property (@(posedge clk) disable iff (!chk_en)
      enc_valid |-> enc_data == exp_enc_data)
      else report_mismatch("enc_data", $sampled(exp_enc_data), $sampled(enc_data));
   a_enc_ecc: assert property (@(posedge clk) disable iff (!chk_en)
      enc_valid |-> enc_ecc == exp_enc_ecc)
      else report_mismatch("enc_ecc", 32'($sampled(exp_enc_ecc)), 32'($sampled(enc_ecc)));
   a_fix_valid: assert property (@(posedge clk) disable iff (!chk_en)
      fix_valid == exp_fix_valid)
      else report_mismatch("fix_valid", 32'($sampled(exp_fix_valid)), 32'($sampled(fix_valid)));
   a_single: assert property (@(posedge clk) disable iff (!chk_en)
      single_err == exp_single)
      else report_mismatch("single_err", 32'($sampled(exp_single)), 32'($sampled(single_err)));
   a_double: assert property (@(posedge clk) disable iff (!chk_en)
      double_err == exp_double)
      else report_mismatch("double_err", 32'($sampled(exp_double)), 32'($sampled(double_err)));
   a_fix_data: assert property (@(posedge clk) disable iff (!chk_en)
      (fix_valid && exp_fix_chk) |-> fix_data == exp_fix_data)
      else report_mismatch("fix_data", $sampled(exp_fix_data), $sampled(fix_data));
   a_fix_ecc: assert property (@(posedge clk) disable iff (!chk_en)
      (fix_valid && exp_fix_chk) |-> fix_ecc == exp_fix_ecc)
      else report_mismatch("fix_ecc", 32'($sampled(exp_fix_ecc)), 32'($sampled(fix_ecc)));
   a_idle_flags: assert property (@(posedge clk) disable iff (!chk_en)
      !fix_valid |-> !(single_err || double_err))
      else report_mismatch("error flags while idle", 32'd0,
                           32'({$sampled(double_err), $sampled(single_err)}));

   initial begin : main
      logic [31:0] r;
      $timeformat(-9, 1, " ns", 10);
      rng      = SEED;
      rst_l    = 1'b0;
      chk_en   = 1'b0;
      // words offered during reset must not come out
      wr_valid = 1'b1;
      wr_data  = '1;
      rd_valid = 1'b1;
      rd_data  = '1;
      rd_ecc   = '0;
      sed_ded  = 1'b0;

      @(negedge clk);
      chk_en = 1'b1;   // flops cleared by the first edge in reset
      repeat (7) @(negedge clk);
      rst_l = 1'b1;
      drive_write(1'b0);
      drive_read(1'b0);

      cycles = 0;
      while (wr_sent < NUM_WORDS || rd_sent < NUM_WORDS) begin
         @(negedge clk);
         cycles++;
         if (cycles > RUN_LIMIT) begin
            $display("stimulus loop ran out of cycles before all words were sent");
            stop_with_fail();
         end
         next_random(r);
         drive_write(wr_sent < NUM_WORDS && r[3:0] != 4'd0);   // idle about 1 in 16
         drive_read(rd_sent < NUM_WORDS && r[7:4] != 4'd0);
      end
      @(negedge clk);
      drive_write(1'b0);
      drive_read(1'b0);

      // every word sent must come out
      cycles = 0;
      while (enc_seen != wr_sent || fix_seen != rd_sent) begin
         @(posedge clk);
         cycles++;
         if (cycles > DRAIN_LIMIT) begin
            $display("timeout waiting for the last words to leave the pipeline");
            stop_with_fail();
         end
      end
      repeat (6) @(negedge clk);   // idle tail for the valid and flag checks

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/ecc_pkg.sv
source/ecc_encode_stage.sv
source/ecc_syndrome_stage.sv
source/ecc_correct_stage.sv
source/ecc_pipe_top.sv
verif/ecc_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run of the SECDED pipeline testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/Vecc_pipe_tb: flist.f $(wildcard source/*.sv include/*.svh verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module ecc_pipe_tb -f flist.f -o Vecc_pipe_tb

# passes only when the pass line shows up in the simulation output
test: obj_dir/Vecc_pipe_tb
	./obj_dir/Vecc_pipe_tb | tee /dev/stderr | grep -qF "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
